// ==== filelist.f ====
source/dcache_pkg.sv
source/dcache_fsm.sv
source/dcache_reqbuf.sv
source/dcache_tagv.sv
source/dcache_data.sv
source/dcache_lru.sv
source/dcache_wb_master.sv
source/dcache_top.sv
testbench/wb_mem_model.sv
testbench/tb_dcache.sv

// ==== source/dcache_data.sv ====
module dcache_data #(
    parameter int index_width = dcache_pkg::index_width
) (
    input  logic                              clk,
    input  logic [index_width-1:0]            index,
    input  logic [dcache_pkg::num_ways-1:0]   we,
    input  logic                              replace,
    input  logic [3:0]                        wstrb,
    input  logic [31:0]                       wdata,
    input  logic [31:0]                       refill_data,
    input  logic                              rd_way,
    output logic [31:0]                       rdata
);
    import dcache_pkg::*;

    localparam int sets = 2 ** index_width;

    logic [31:0] mem [num_ways][sets];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (we[w]) begin
                if (replace) begin
                    mem[w][index] <= refill_data;   // whole line
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b])
                            mem[w][index][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assign rdata = mem[rd_way][index];

endmodule

// ==== source/dcache_fsm.sv ====
module dcache_fsm (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               req_valid,
    input  logic                               req_op,
    input  logic                               flush,
    input  logic [dcache_pkg::num_ways-1:0]    hit,
    input  logic                               buf_we_req,
    input  logic                               buf_uncached,
    input  dcache_pkg::cache_op_t              buf_opcode,
    input  logic                               buf_index_way,
    input  logic                               victim_way,
    input  logic                               addr_ok,
    input  logic                               data_ok,
    output logic                               req_ready,
    output logic                               buf_we,
    output logic                               resp_valid,
    output logic                               resp_sel_refill,
    output logic                               resp_way,
    output logic                               op_done,
    output logic                               mem_req,
    output logic                               mem_wr,
    output logic [dcache_pkg::num_ways-1:0]    data_we,
    output logic                               replace,
    output logic [dcache_pkg::num_ways-1:0]    tagv_inval,
    output logic                               tagv_init,
    output logic                               use0,
    output logic                               use1,
    output logic [31:0]                        hit_count,
    output logic [31:0]                        miss_count
);
    import dcache_pkg::*;

    fsm_state_t state;
    fsm_state_t next_state;
    fsm_state_t accept_state;
    logic       miss;
    logic       hit_inc;
    logic       miss_inc;

    assign miss   = ~(|hit) | buf_uncached;
    assign buf_we = req_ready;

    // where a request taken this cycle goes
    assign accept_state = !req_valid ? st_idle : (req_op ? st_operation : st_lookup);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= st_idle;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            state <= next_state;
            if (hit_inc)
                hit_count <= hit_count + 32'd1;
            if (miss_inc)
                miss_count <= miss_count + 32'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state

    always_comb begin
        next_state = state;
        case (state)
            st_idle: next_state = accept_state;
            st_lookup: begin
                if (flush)
                    next_state = st_flush;
                else if (buf_we_req)
                    next_state = miss ? st_miss_w : st_hit_w;
                else if (miss)
                    next_state = st_miss_r_wait;
                else
                    next_state = accept_state;
            end
            st_miss_r_wait: if (data_ok) next_state = st_miss_r_fill;
            st_miss_r_fill: next_state = accept_state;
            st_miss_w, st_hit_w: if (addr_ok) next_state = accept_state;
            st_operation, st_flush: next_state = flush ? st_flush : accept_state;
            default: next_state = st_idle;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // outputs

    always_comb begin
        req_ready       = 1'b0;
        resp_valid      = 1'b0;
        resp_sel_refill = 1'b0;
        resp_way        = ~hit[0];
        op_done         = 1'b0;
        mem_req         = 1'b0;
        mem_wr          = 1'b0;
        data_we         = '0;
        replace         = 1'b0;
        tagv_inval      = '0;
        tagv_init       = 1'b0;
        use0            = 1'b0;
        use1            = 1'b0;
        hit_inc         = 1'b0;
        miss_inc        = 1'b0;
        case (state)
            st_idle, st_flush: req_ready = 1'b1;
            st_lookup: begin
                if (flush) begin
                    req_ready = 1'b1;   // request dropped
                end else begin
                    hit_inc  = ~miss;
                    miss_inc = miss;
                    if (buf_uncached)
                        tagv_inval = hit;   // strongly-ordered never keeps a line
                    if (buf_we_req || miss) begin
                        mem_req = 1'b1;
                        mem_wr  = buf_we_req;
                    end
                    if (!miss) begin
                        use0 = hit[0];
                        use1 = hit[1];
                        if (buf_we_req) begin
                            data_we = hit;   // write-through, update hit way
                        end else begin
                            resp_valid = 1'b1;
                            req_ready  = 1'b1;
                        end
                    end
                end
            end
            st_miss_r_wait: mem_req = 1'b1;
            st_miss_r_fill: begin
                req_ready       = 1'b1;
                resp_valid      = 1'b1;
                resp_sel_refill = 1'b1;
                if (!buf_uncached) begin
                    replace             = 1'b1;
                    data_we[victim_way] = 1'b1;
                    use0                = ~victim_way;
                    use1                = victim_way;
                end
            end
            st_miss_w, st_hit_w: begin
                mem_req   = 1'b1;
                mem_wr    = 1'b1;
                req_ready = addr_ok;   // stall until bus takes it
            end
            st_operation: begin
                req_ready = 1'b1;
                op_done   = 1'b1;
                if (!flush) begin
                    case (buf_opcode)
                        op_init_tag:    tagv_init = 1'b1;
                        op_inval_index: tagv_inval[buf_index_way] = 1'b1;
                        op_inval_hit:   tagv_inval = hit;
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

    a_data_we_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(data_we));

    a_mem_req_state: assert property (@(posedge clk) disable iff (!rstn)
        $rose(mem_req) |-> state == st_lookup);

endmodule

// ==== source/dcache_lru.sv ====
module dcache_lru #(
    parameter int index_width = dcache_pkg::index_width
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [index_width-1:0]  index,
    input  logic                    use0,
    input  logic                    use1,
    output logic                    victim_way
);
    localparam int sets = 2 ** index_width;

    logic [sets-1:0] lru;   // 1 means way 1 is older

    always_ff @(posedge clk) begin
        if (!rstn)
            lru <= '0;
        else if (use0)
            lru[index] <= 1'b1;
        else if (use1)
            lru[index] <= 1'b0;
    end

    assign victim_way = lru[index];

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry

    parameter int index_width  = 4;    // 16 sets
    parameter int offset_width = 2;    // byte within word
    parameter int num_ways     = 2;
    parameter int tag_width    = 32 - index_width - offset_width;
    parameter int uncached_bit = 31;

    ////////////////////////////////////////////////////////////
    // encodings

    typedef enum logic [1:0] {
        op_init_tag    = 2'd0,
        op_inval_index = 2'd1,
        op_inval_hit   = 2'd2
    } cache_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_r_wait,
        st_miss_r_fill,
        st_miss_w,
        st_hit_w,
        st_operation,
        st_flush
    } fsm_state_t;

endpackage

// ==== source/dcache_reqbuf.sv ====
module dcache_reqbuf #(
    parameter int index_width = dcache_pkg::index_width,
    parameter int tag_width   = dcache_pkg::tag_width
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       load,
    input  logic [31:0]                req_addr,
    input  logic                       req_we,
    input  logic [31:0]                req_wdata,
    input  logic [3:0]                 req_wstrb,
    input  dcache_pkg::cache_op_t      req_opcode,
    output logic [31:0]                buf_addr,
    output logic                       buf_we_req,
    output logic [3:0]                 buf_wstrb,
    output logic [31:0]                buf_wdata,
    output dcache_pkg::cache_op_t      buf_opcode,
    output logic [tag_width-1:0]       buf_tag,
    output logic [index_width-1:0]     buf_index,
    output logic                       buf_uncached,
    output logic                       buf_index_way
);
    import dcache_pkg::*;

    always_ff @(posedge clk) begin
        if (!rstn)
            buf_we_req <= 1'b0;
        else if (load)
            buf_we_req <= req_we;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            buf_addr   <= req_addr;
            buf_wdata  <= req_wdata;
            buf_wstrb  <= req_wstrb;
            buf_opcode <= req_opcode;
        end
    end

    // uncached alias drops bit 31 so it hits the cached line
    assign buf_tag       = {1'b0, buf_addr[uncached_bit-1:offset_width+index_width]};
    assign buf_index     = buf_addr[offset_width +: index_width];
    assign buf_uncached  = buf_addr[uncached_bit];
    assign buf_index_way = buf_addr[0];   // way select for cache ops

endmodule

// ==== source/dcache_tagv.sv ====
module dcache_tagv #(
    parameter int index_width = dcache_pkg::index_width,
    parameter int tag_width   = dcache_pkg::tag_width
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [index_width-1:0]            index,
    input  logic [tag_width-1:0]              tag,
    input  logic [dcache_pkg::num_ways-1:0]   fill_we,
    input  logic [dcache_pkg::num_ways-1:0]   inval,
    input  logic                              init,
    input  logic                              init_way,
    output logic [dcache_pkg::num_ways-1:0]   hit
);
    import dcache_pkg::*;

    localparam int sets = 2 ** index_width;

    logic [tag_width-1:0] tag_mem [num_ways][sets];
    logic [sets-1:0]      valid   [num_ways];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < num_ways; w++)
                valid[w] <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (init && init_way == w)
                    valid[w][index] <= 1'b0;
                else if (inval[w])
                    valid[w][index] <= 1'b0;
                else if (fill_we[w])
                    valid[w][index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (init && init_way == w)
                tag_mem[w][index] <= '0;
            else if (fill_we[w])
                tag_mem[w][index] <= tag;
        end
    end

    // compare on the registered index
    always_comb begin
        for (int w = 0; w < num_ways; w++)
            hit[w] = valid[w][index] && (tag_mem[w][index] == tag);
    end

endmodule

// ==== source/dcache_top.sv ====
module dcache_top #(
    parameter int index_width = dcache_pkg::index_width
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  logic                   req_we,
    input  logic [31:0]            req_addr,
    input  logic [31:0]            req_wdata,
    input  logic [3:0]             req_wstrb,
    input  logic                   req_op,
    input  dcache_pkg::cache_op_t  req_opcode,
    output logic                   resp_valid,
    output logic [31:0]            resp_rdata,
    output logic                   op_done,
    input  logic                   flush,
    output logic [31:0]            hit_count,
    output logic [31:0]            miss_count,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [31:0]            wb_adr,
    output logic [31:0]            wb_dat_w,
    output logic [3:0]             wb_sel,
    input  logic [31:0]            wb_rdata,
    input  logic                   wb_ack
);
    import dcache_pkg::*;

    localparam int tag_w = 32 - index_width - offset_width;

    logic [31:0]            buf_addr;
    logic                   buf_we_req;
    logic [3:0]             buf_wstrb;
    logic [31:0]            buf_wdata;
    cache_op_t              buf_opcode;
    logic [tag_w-1:0]       buf_tag;
    logic [index_width-1:0] buf_index;
    logic                   buf_uncached;
    logic                   buf_index_way;
    logic                   buf_we;
    logic [num_ways-1:0]    hit;
    logic [num_ways-1:0]    data_we;
    logic [num_ways-1:0]    tagv_inval;
    logic                   tagv_init;
    logic                   replace;
    logic                   use0;
    logic                   use1;
    logic                   victim_way;
    logic                   resp_sel_refill;
    logic                   resp_way;
    logic                   mem_req;
    logic                   mem_wr;
    logic                   addr_ok;
    logic                   data_ok;
    logic [31:0]            mem_rdata;
    logic [31:0]            data_rdata;

    assign resp_rdata = resp_sel_refill ? mem_rdata : data_rdata;

    dcache_fsm i_fsm (
        .clk, .rstn, .req_valid, .req_op, .flush, .hit, .buf_we_req, .buf_uncached,
        .buf_opcode, .buf_index_way, .victim_way, .addr_ok, .data_ok, .req_ready, .buf_we,
        .resp_valid, .resp_sel_refill, .resp_way, .op_done, .mem_req, .mem_wr, .data_we,
        .replace, .tagv_inval, .tagv_init, .use0, .use1, .hit_count, .miss_count
    );

    dcache_reqbuf #(.index_width(index_width), .tag_width(tag_w)) i_reqbuf (
        .clk, .rstn, .load(buf_we), .req_addr, .req_we, .req_wdata, .req_wstrb, .req_opcode,
        .buf_addr, .buf_we_req, .buf_wstrb, .buf_wdata, .buf_opcode, .buf_tag, .buf_index,
        .buf_uncached, .buf_index_way
    );

    dcache_tagv #(.index_width(index_width), .tag_width(tag_w)) i_tagv (
        .clk, .rstn, .index(buf_index), .tag(buf_tag), .fill_we(data_we), .inval(tagv_inval),
        .init(tagv_init), .init_way(buf_index_way), .hit
    );

    dcache_data #(.index_width(index_width)) i_data (
        .clk, .index(buf_index), .we(data_we), .replace, .wstrb(buf_wstrb), .wdata(buf_wdata),
        .refill_data(mem_rdata), .rd_way(resp_way), .rdata(data_rdata)
    );

    dcache_lru #(.index_width(index_width)) i_lru (
        .clk, .rstn, .index(buf_index), .use0, .use1, .victim_way
    );

    dcache_wb_master i_wb_master (
        .clk, .rstn, .mem_req, .mem_wr, .addr(buf_addr), .wdata(buf_wdata), .wstrb(buf_wstrb),
        .addr_ok, .data_ok, .mem_rdata, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel,
        .wb_rdata, .wb_ack
    );

endmodule

// ==== source/dcache_wb_master.sv ====
module dcache_wb_master (
    input  logic        clk,
    input  logic        rstn,
    input  logic        mem_req,
    input  logic        mem_wr,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] mem_rdata,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    output logic [31:0] wb_dat_w,
    output logic [3:0]  wb_sel,
    input  logic [31:0] wb_rdata,
    input  logic        wb_ack
);
    import dcache_pkg::*;

    logic start;
    logic done;

    assign start = mem_req & ~wb_cyc;
    assign done  = wb_cyc & wb_ack;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else if (done) begin
            wb_cyc <= 1'b0;   // earliest restart is next edge
            wb_stb <= 1'b0;
        end else if (start) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= {addr[31:offset_width], {offset_width{1'b0}}};
            wb_dat_w <= wdata;
            wb_sel   <= mem_wr ? wstrb : 4'hf;   // reads fetch the whole word
        end
        if (done && !wb_we)
            mem_rdata <= wb_rdata;
    end

    assign addr_ok = done & wb_we;
    assign data_ok = done & ~wb_we;

    a_stb_cyc: assert property (@(posedge clk) disable iff (!rstn)
        wb_stb |-> wb_cyc);

    a_hold_until_ack: assert property (@(posedge clk) disable iff (!rstn)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr) && $stable(wb_we));

endmodule

// ==== testbench/tb_dcache.sv ====
module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    localparam int req_total      = 8 + 20 + 15 + 22 + 18 + 6;
    localparam int timeout_cycles = 40 * req_total + 10;

    logic        clk = 1'b0;
    logic        rstn;
    logic        req_valid;
    logic        req_ready;
    logic        req_we;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_wstrb;
    logic        req_op;
    cache_op_t   req_opcode;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        op_done;
    logic        flush;
    logic [31:0] hit_count;
    logic [31:0] miss_count;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_rdata;
    logic        wb_ack;
    int          read_count;

    int seed = 70;
    int cycles = 0;
    int bus_cycles = 0;
    int checks = 0;
    int errors = 0;
    int checks_at_start = 0;
    int errors_at_start = 0;

    ////////////////////////////////////////////////////////////
    // reference model state

    logic        mv  [16][2];   // valid
    logic [24:0] mt  [16][2];   // tag, addr[30:6]
    logic        ml  [16];      // victim way
    logic [31:0] img [256];
    int exp_hits = 0;
    int exp_misses = 0;
    int exp_reads = 0;
    int exp_cycles = 0;

    int          n_resp;
    int          n_done;
    logic [31:0] got_rdata;

    dcache_top #(.index_width(4)) i_dcache_top (.*);

    wb_mem_model #(.seed_init(70)) i_mem (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (rstn && wb_cyc && wb_ack)
            bus_cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: no finish after %0d cycles", timeout_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-22s %0d checks, %0d errors", name,
                 checks - checks_at_start, errors - errors_at_start);
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] pool_addr(input int t, input int i);
        return ((t + 1) << 6) | ((i == 0 ? 3 : 9) << 2);
    endfunction

    function automatic logic way_hit(input logic [31:0] addr, input int w);
        return mv[addr[5:2]][w] && (mt[addr[5:2]][w] == addr[30:6]);
    endfunction

    task automatic model_access(input logic we, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] wstrb);
        logic [3:0] idx;
        logic       h0;
        logic       h1;
        logic       way;
        logic       miss;
        idx  = addr[5:2];
        h0   = way_hit(addr, 0);
        h1   = way_hit(addr, 1);
        way  = !h0;
        miss = !(h0 || h1) || addr[31];
        if (miss)
            exp_misses++;
        else
            exp_hits++;
        if (we || miss)
            exp_cycles++;
        if (addr[31] && (h0 || h1))
            mv[idx][way] = 1'b0;   // strongly-ordered drops the line
        if (!miss)
            ml[idx] = !way;
        if (we) begin
            for (int b = 0; b < 4; b++)
                if (wstrb[b])
                    img[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
        end else if (miss) begin
            exp_reads++;
            if (!addr[31]) begin
                way          = ml[idx];
                mv[idx][way] = 1'b1;
                mt[idx][way] = addr[30:6];
                ml[idx]      = !way;
            end
        end
    endtask

    // one request, waits for the cache to be ready again
    task automatic run_req(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, input logic op, input cache_op_t opcode,
                           input logic fl);
        logic done;
        n_resp = 0;
        n_done = 0;
        @(negedge clk);
        req_valid  = 1'b1;
        req_we     = we;
        req_addr   = addr;
        req_wdata  = wdata;
        req_wstrb  = wstrb;
        req_op     = op;
        req_opcode = opcode;
        flush      = fl;
        #1;
        while (!req_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req_valid = 1'b0;
        do begin
            #1;
            if (resp_valid) begin
                n_resp++;
                got_rdata = resp_rdata;
            end
            if (op_done)
                n_done++;
            done = req_ready;
            if (!done)
                @(negedge clk);
        end while (!done);
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic check_counters;
        check("hit_count", hit_count, exp_hits);
        check("miss_count", miss_count, exp_misses);
        check("read_count", read_count, exp_reads);
        check("bus cycles", bus_cycles, exp_cycles);
    endtask

    task automatic access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb);
        logic [31:0] exp_data;
        model_access(we, addr, wdata, wstrb);
        exp_data = img[addr[9:2]];
        run_req(we, addr, wdata, wstrb, 1'b0, op_init_tag, 1'b0);
        check("resp_valid pulses", n_resp, we ? 0 : 1);
        if (we)
            check("memory word", i_mem.mem[addr[9:2]], exp_data);
        else
            check("resp_rdata", got_rdata, exp_data);
        check_counters();
    endtask

    task automatic cache_op(input cache_op_t opcode, input logic [31:0] addr);
        logic [3:0] idx;
        idx = addr[5:2];
        case (opcode)
            op_init_tag: begin
                mv[idx][addr[0]] = 1'b0;
                mt[idx][addr[0]] = '0;
            end
            op_inval_index: mv[idx][addr[0]] = 1'b0;
            default: begin
                if (way_hit(addr, 0))
                    mv[idx][0] = 1'b0;
                else if (way_hit(addr, 1))
                    mv[idx][1] = 1'b0;
            end
        endcase
        run_req(1'b0, addr, 32'd0, 4'd0, 1'b1, opcode, 1'b0);
        check("op_done pulses", n_done, 1);
        check("resp_valid pulses", n_resp, 0);
        check_counters();
    endtask

    task automatic flushed_load(input logic [31:0] addr);
        run_req(1'b0, addr, 32'd0, 4'd0, 1'b0, op_init_tag, 1'b1);
        check("resp_valid pulses", n_resp, 0);
        check_counters();   // nothing counted, no bus cycle
    endtask

    initial begin
        logic [31:0] a;
        int          t;
        int          lru_seq [6];
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_we     = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_wstrb  = '0;
        req_op     = 1'b0;
        req_opcode = op_init_tag;
        flush      = 1'b0;
        lru_seq    = '{0, 1, 0, 2, 0, 1};
        for (int s = 0; s < 16; s++) begin
            ml[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                mv[s][w] = 1'b0;
                mt[s][w] = '0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < 256; i++)
            img[i] = i_mem.mem[i];

        for (int k = 0; k < 4; k++) begin
            a = pool_addr(rand_below(3), rand_below(2));
            access(1'b0, a, 32'd0, 4'd0);
            access(1'b0, a, 32'd0, 4'd0);
        end
        end_test("load miss then hit");

        for (int k = 0; k < 10; k++) begin
            a = pool_addr(rand_below(3), rand_below(2));
            access(1'b1, a, $random(seed), rand_below(16));
            access(1'b0, a, 32'd0, 4'd0);
        end
        end_test("store write-through");

        for (int k = 0; k < 5; k++) begin
            a = pool_addr(rand_below(3), rand_below(2));
            access(1'b0, a, 32'd0, 4'd0);
            access(1'b0, a | 32'h8000_0000, 32'd0, 4'd0);
            access(1'b0, a, 32'd0, 4'd0);   // line was dropped
        end
        end_test("uncached access");

        t = rand_below(2);
        for (int k = 0; k < 6; k++)
            access(1'b0, pool_addr(lru_seq[k], t), 32'd0, 4'd0);
        for (int k = 0; k < 16; k++) begin
            a = pool_addr(rand_below(3), rand_below(2));
            if (rand_below(8) == 0)
                a[31] = 1'b1;
            access(rand_below(4) == 0, a, $random(seed), rand_below(16));
        end
        end_test("lru replacement");

        for (int k = 0; k < 6; k++) begin
            a = pool_addr(rand_below(3), rand_below(2));
            access(1'b0, a, 32'd0, 4'd0);
            cache_op(cache_op_t'(k % 3), a | way_hit(a, 1));
            access(1'b0, a, 32'd0, 4'd0);
        end
        end_test("cache ops");

        for (int k = 0; k < 3; k++) begin
            a = pool_addr(rand_below(3), rand_below(2));
            flushed_load(a);
            access(1'b0, a, 32'd0, 4'd0);
        end
        end_test("flush");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== testbench/wb_mem_model.sv ====
module wb_mem_model #(
    parameter int seed_init = 70
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    output logic [31:0] wb_rdata,
    output logic        wb_ack,
    output int          read_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [256];
    logic [7:0]  word;
    logic        busy;
    int          wait_cnt;
    int          seed;

    assign word = wb_adr[9:2];   // bit 31 aliases onto the same word

    initial begin
        seed = seed_init;
        for (int i = 0; i < 256; i++)
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
    end

    always @(posedge clk) begin
        if (!rstn) begin
            wb_ack     <= 1'b0;
            wb_rdata   <= '0;
            busy       <= 1'b0;
            read_count <= 0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;   // single-cycle ack
        end else if (wb_cyc && wb_stb && !busy) begin
            busy     <= 1'b1;
            wait_cnt <= $unsigned($random(seed)) % 4;
        end else if (busy) begin
            if (wait_cnt == 0) begin
                busy   <= 1'b0;
                wb_ack <= 1'b1;
                if (wb_we) begin
                    for (int b = 0; b < 4; b++)
                        if (wb_sel[b])
                            mem[word][8*b +: 8] <= wb_dat_w[8*b +: 8];
                end else begin
                    wb_rdata   <= mem[word];
                    read_count <= read_count + 1;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule
